//--- src.f
design/const_pack.sv
design/adc_code_decode.sv
design/mm_cdr_loop.sv
design/pi_ctl_gen.sv
design/dcore_cfg_regs.sv
design/digital_core.sv
tb/digital_core_checker.sv
tb/digital_core_tb.sv

//--- tb/digital_core_tb.sv
`timescale 1ns/1ps

module digital_core_tb;

	localparam integer ClkPeriod = 100;
	localparam integer ResetCycles = 5;
	localparam logic [31:0] Seed = 32'h3232_323b;
	localparam integer DrainLimit = 20;   // cycles to empty the pipe

	logic clk_adc;
	logic rst_i;
	logic adc_valid_i;
	logic [const_pack::Nti*const_pack::Nadc-1:0] adcout_i;
	logic [const_pack::Nti-1:0] adcout_sign_i;
	logic cfg_wr_i;
	const_pack::cfg_op_t cfg_op_i;
	logic [const_pack::Ncfg-1:0] cfg_data_i;
	logic [const_pack::Nti-1:0] data_o;
	logic data_valid_o;
	logic [const_pack::Nout*const_pack::Npi-1:0] pi_ctl_o;
	logic ctl_valid_o;

	int err_cnt;
	int data_cnt;
	int ctl_cnt;
	int words_sent;
	int tout_cnt;
	logic [31:0] lfsr;

	digital_core u_digital_core (
		.clk_adc(clk_adc),
		.rst_i(rst_i),
		.adc_valid_i(adc_valid_i),
		.adcout_i(adcout_i),
		.adcout_sign_i(adcout_sign_i),
		.cfg_wr_i(cfg_wr_i),
		.cfg_op_i(cfg_op_i),
		.cfg_data_i(cfg_data_i),
		.data_o(data_o),
		.data_valid_o(data_valid_o),
		.pi_ctl_o(pi_ctl_o),
		.ctl_valid_o(ctl_valid_o)
	);

	digital_core_checker u_checker (
		.clk_adc(clk_adc),
		.rst_i(rst_i),
		.adc_valid_i(adc_valid_i),
		.adcout_i(adcout_i),
		.adcout_sign_i(adcout_sign_i),
		.cfg_wr_i(cfg_wr_i),
		.cfg_op_i(cfg_op_i),
		.cfg_data_i(cfg_data_i),
		.data_i(data_o),
		.data_valid_i(data_valid_o),
		.pi_ctl_i(pi_ctl_o),
		.ctl_valid_i(ctl_valid_o),
		.err_cnt_o(err_cnt),
		.data_cnt_o(data_cnt),
		.ctl_cnt_o(ctl_cnt)
	);

	initial begin
		clk_adc = 1'b0;
		forever #(ClkPeriod/2) clk_adc = ~clk_adc;
	end

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[31]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic send_words(input int count, input bit gaps);
		logic [31:0] mag;
		logic [31:0] sgn;
		logic [31:0] gap;
		int sent;
		sent = 0;
		while (sent < count) begin
			take_bits(2, gap);
			@(posedge clk_adc);
			if (gaps && gap[1:0] == 2'd0) begin
				adc_valid_i <= 1'b0;   // idle slot
			end else begin
				take_bits(32, mag);
				take_bits(4, sgn);
				adc_valid_i <= 1'b1;
				adcout_i <= mag;
				adcout_sign_i <= sgn[3:0];
				sent++;
			end
		end
		@(posedge clk_adc);
		adc_valid_i <= 1'b0;
		words_sent += count;
	endtask

	task automatic cfg_write(input const_pack::cfg_op_t op, input logic [15:0] data);
		@(posedge clk_adc);
		cfg_wr_i <= 1'b1;
		cfg_op_i <= op;
		cfg_data_i <= data;
		@(posedge clk_adc);
		cfg_wr_i <= 1'b0;
	endtask

	task automatic wait_drain(input string what);
		int cycles;
		cycles = 0;
		while (ctl_cnt != words_sent && cycles < DrainLimit) begin
			@(posedge clk_adc);
			cycles++;
		end
		if (ctl_cnt != words_sent) begin
			$display("timeout in %s: only %0d of %0d code sets came out", what, ctl_cnt,
				words_sent);
			tout_cnt++;
		end
	endtask

	initial begin
		lfsr = Seed;
		words_sent = 0;
		tout_cnt = 0;
		rst_i = 1'b1;
		adc_valid_i = 1'b0;
		adcout_i = '0;
		adcout_sign_i = '0;
		cfg_wr_i = 1'b0;
		cfg_op_i = const_pack::CFG_KI;
		cfg_data_i = '0;
		repeat (ResetCycles) @(posedge clk_adc);
		rst_i <= 1'b0;

		send_words(40, 1'b1);   // decode with gaps
		wait_drain("decode");

		// tracking at three loop gains, gaps in the last run
		cfg_write(const_pack::CFG_OFFSET, 16'h0040);
		cfg_write(const_pack::CFG_OFFSET, 16'h0280);
		cfg_write(const_pack::CFG_KI, 16'd0);
		send_words(50, 1'b0);
		cfg_write(const_pack::CFG_KI, 16'd3);
		send_words(50, 1'b0);
		cfg_write(const_pack::CFG_KI, 16'd7);
		send_words(30, 1'b1);
		wait_drain("tracking");

		cfg_write(const_pack::CFG_KI, 16'd0);
		cfg_write(const_pack::CFG_MODE, 16'h0003);   // freeze
		send_words(30, 1'b0);
		cfg_write(const_pack::CFG_MODE, 16'h0001);
		send_words(30, 1'b0);
		wait_drain("freeze");

		cfg_write(const_pack::CFG_MODE, 16'h0000);   // manual
		cfg_write(const_pack::CFG_MANUAL, 16'h00a5);
		send_words(10, 1'b0);
		cfg_write(const_pack::CFG_MANUAL, 16'h01f0);
		send_words(10, 1'b0);

		// offsets near the top so the sum wraps
		for (int idx = 0; idx < const_pack::Nout; idx++) begin
			cfg_write(const_pack::CFG_OFFSET, 16'((idx << 9) | (511 - 3 * idx)));
			send_words(8, 1'b0);
		end
		cfg_write(const_pack::CFG_MODE, 16'h0001);
		send_words(20, 1'b1);
		wait_drain("final");
		repeat (4) @(posedge clk_adc);

		$display("errors %0d, timeouts %0d, data words %0d, code sets %0d of %0d", err_cnt,
			tout_cnt, data_cnt, ctl_cnt, words_sent);
		if (err_cnt == 0 && tout_cnt == 0 && ctl_cnt == words_sent) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- tb/digital_core_checker.sv
`timescale 1ns/1ps

module digital_core_checker (
	input wire logic clk_adc,
	input wire logic rst_i,
	input wire logic adc_valid_i,
	input wire logic [const_pack::Nti*const_pack::Nadc-1:0] adcout_i,
	input wire logic [const_pack::Nti-1:0] adcout_sign_i,
	input wire logic cfg_wr_i,
	input wire const_pack::cfg_op_t cfg_op_i,
	input wire logic [const_pack::Ncfg-1:0] cfg_data_i,
	input wire logic [const_pack::Nti-1:0] data_i,
	input wire logic data_valid_i,
	input wire logic [const_pack::Nout*const_pack::Npi-1:0] pi_ctl_i,
	input wire logic ctl_valid_i,
	output int err_cnt_o,
	output int data_cnt_o,
	output int ctl_cnt_o
);

	localparam integer Np = const_pack::Npi;
	localparam integer Nt = const_pack::Nti;
	localparam integer Na = const_pack::Nadc;

	// model of the dut registers after the last rising edge
	logic [2:0] m_ki;
	logic m_en;
	logic m_frz;
	logic [Np-1:0] m_man;
	logic [const_pack::Nout*Np-1:0] m_off;
	logic s1_vld;                  // decode stage
	logic [Nt*32-1:0] s1_samp;     // one int per lane
	logic [Nt-1:0] s1_dec;
	logic s2_vld;                  // loop stage
	logic [15:0] m_acc;
	int hist_samp;
	logic hist_dec;
	logic s3_vld;                  // code stage
	logic [const_pack::Nout*Np-1:0] s3_code;

	function automatic int ref_sample(input logic [Na-1:0] mag, input logic sgn);
		return sgn ? int'(mag) : -int'(mag);
	endfunction

	function automatic int dsign(input logic d);
		return d ? 1 : -1;
	endfunction

	// mm sum with lane 0 looking back at lane 3 of the previous word
	function automatic int ref_pd(input logic [Nt*32-1:0] s, input logic [Nt-1:0] d,
		input int ps, input logic pdec);
		int sum;
		int cur;
		int prv;
		logic dprv;
		sum = 0;
		for (int k = 0; k < Nt; k++) begin
			cur = $signed(s[k*32 +: 32]);
			if (k == 0) begin
				prv = ps;
				dprv = pdec;
			end else begin
				prv = $signed(s[(k-1)*32 +: 32]);
				dprv = d[k-1];
			end
			sum += dsign(dprv) * cur - dsign(d[k]) * prv;
		end
		return sum;
	endfunction

	function automatic logic [15:0] ref_acc(input logic [15:0] acc, input int pd,
		input logic [2:0] ki);
		int step;
		step = pd >>> ki;
		return acc + step[15:0];   // mod 2^16
	endfunction

	function automatic logic [Np-1:0] ref_code(input logic [Np-1:0] base,
		input logic [Np-1:0] off);
		return base + off;
	endfunction

	task automatic report_err(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		$display("ERR t=%0t %s expected %0h got %0h", $time, name, exp_v, act_v);
		err_cnt_o++;
	endtask

	task automatic model_reset();
		m_ki = '0;
		m_en = 1'b1;
		m_frz = 1'b0;
		m_man = '0;
		m_off = '0;
		s1_vld = 1'b0;
		s2_vld = 1'b0;
		s3_vld = 1'b0;
		m_acc = '0;
		hist_samp = 0;
		hist_dec = 1'b0;
	endtask

	initial begin
		err_cnt_o = 0;
		data_cnt_o = 0;
		ctl_cnt_o = 0;
		model_reset();
	end

	// one model step per clock on the falling edge
	always @(negedge clk_adc) begin : model_step
		logic [Np-1:0] base;
		if (rst_i !== 1'b0) begin
			model_reset();
		end else begin
			if (data_valid_i === 1'b1)
				data_cnt_o++;
			if (ctl_valid_i === 1'b1)
				ctl_cnt_o++;
			if (data_valid_i !== s1_vld) begin
				report_err("data_valid_o", s1_vld, data_valid_i);
			end else if (s1_vld && data_i !== s1_dec) begin
				report_err("data_o", s1_dec, data_i);
			end
			if (ctl_valid_i !== s3_vld) begin
				report_err("ctl_valid_o", s3_vld, ctl_valid_i);
			end else if (s3_vld) begin
				for (int n = 0; n < const_pack::Nout; n++) begin
					if (pi_ctl_i[n*Np +: Np] !== s3_code[n*Np +: Np])
						report_err($sformatf("pi_ctl_o[%0d]", n), s3_code[n*Np +: Np],
							pi_ctl_i[n*Np +: Np]);
				end
			end

			// step the next rising edge from the back end forward
			if (s2_vld) begin
				base = m_en ? m_acc[15 -: Np] : m_man;
				for (int n = 0; n < const_pack::Nout; n++)
					s3_code[n*Np +: Np] = ref_code(base, m_off[n*Np +: Np]);
			end
			s3_vld = s2_vld;
			if (s1_vld) begin
				if (m_en && !m_frz)
					m_acc = ref_acc(m_acc,
						ref_pd(s1_samp, s1_dec, hist_samp, hist_dec), m_ki);
				hist_samp = $signed(s1_samp[(Nt-1)*32 +: 32]);
				hist_dec = s1_dec[Nt-1];
			end
			s2_vld = s1_vld;
			if (adc_valid_i) begin
				for (int k = 0; k < Nt; k++)
					s1_samp[k*32 +: 32] = ref_sample(adcout_i[k*Na +: Na],
						adcout_sign_i[k]);
				s1_dec = adcout_sign_i;
			end
			s1_vld = adc_valid_i;
			if (cfg_wr_i) begin
				case (cfg_op_i)
					const_pack::CFG_KI: m_ki = cfg_data_i[2:0];
					const_pack::CFG_MODE: begin
						m_en = cfg_data_i[0];
						m_frz = cfg_data_i[1];
					end
					const_pack::CFG_MANUAL: m_man = cfg_data_i[Np-1:0];
					const_pack::CFG_OFFSET:
						m_off[cfg_data_i[10:9]*Np +: Np] = cfg_data_i[Np-1:0];
				endcase
			end
		end
	end

endmodule

//--- design/digital_core.sv
`timescale 1ns/1ps

`default_nettype none

module digital_core (
	input wire logic clk_adc,   // adc retiming clock
	input wire logic rst_i,

	// adc slice words
	input wire logic adc_valid_i,
	input wire logic [const_pack::Nti*const_pack::Nadc-1:0] adcout_i,
	input wire logic [const_pack::Nti-1:0] adcout_sign_i,

	// config port, stands in for the jtag bank
	input wire logic cfg_wr_i,
	input wire const_pack::cfg_op_t cfg_op_i,
	input wire logic [const_pack::Ncfg-1:0] cfg_data_i,

	// recovered data
	output logic [const_pack::Nti-1:0] data_o,
	output logic data_valid_o,

	// pi control codes to the analog core
	output logic [const_pack::Nout*const_pack::Npi-1:0] pi_ctl_o,
	output logic ctl_valid_o
);

	logic [const_pack::Nti*const_pack::Nsamp-1:0] samp;
	logic [const_pack::Npi-1:0] phase;
	logic phase_valid;

	logic [const_pack::Nki-1:0] ki_shift;
	logic cdr_en;
	logic freeze;
	logic [const_pack::Npi-1:0] manual_code;
	logic [const_pack::Nout*const_pack::Npi-1:0] offsets;

	// decisions double as the recovered data
	adc_code_decode idec (
		.clk_adc(clk_adc),
		.rst_i(rst_i),
		.adc_valid_i(adc_valid_i),
		.adcout_i(adcout_i),
		.adcout_sign_i(adcout_sign_i),
		.samp_o(samp),
		.dec_o(data_o),
		.samp_valid_o(data_valid_o)
	);

	mm_cdr_loop iloop (
		.clk_adc(clk_adc),
		.rst_i(rst_i),
		.samp_i(samp),
		.dec_i(data_o),
		.samp_valid_i(data_valid_o),
		.ki_shift_i(ki_shift),
		.cdr_en_i(cdr_en),
		.freeze_i(freeze),
		.phase_o(phase),
		.phase_valid_o(phase_valid)
	);

	pi_ctl_gen ipi (
		.clk_adc(clk_adc),
		.rst_i(rst_i),
		.phase_i(phase),
		.phase_valid_i(phase_valid),
		.cdr_en_i(cdr_en),
		.manual_code_i(manual_code),
		.offsets_i(offsets),
		.pi_ctl_o(pi_ctl_o),
		.ctl_valid_o(ctl_valid_o)
	);

	dcore_cfg_regs icfg (
		.clk_adc(clk_adc),
		.rst_i(rst_i),
		.cfg_wr_i(cfg_wr_i),
		.cfg_op_i(cfg_op_i),
		.cfg_data_i(cfg_data_i),
		.ki_shift_o(ki_shift),
		.cdr_en_o(cdr_en),
		.freeze_o(freeze),
		.manual_code_o(manual_code),
		.offsets_o(offsets)
	);

endmodule

`default_nettype wire

//--- design/dcore_cfg_regs.sv
`timescale 1ns/1ps

`default_nettype none

module dcore_cfg_regs (
	input wire logic clk_adc,
	input wire logic rst_i,

	// write-only config port
	input wire logic cfg_wr_i,
	input wire const_pack::cfg_op_t cfg_op_i,
	input wire logic [const_pack::Ncfg-1:0] cfg_data_i,

	// loop controls
	output logic [const_pack::Nki-1:0] ki_shift_o,
	output logic cdr_en_o,
	output logic freeze_o,

	// code generator controls
	output logic [const_pack::Npi-1:0] manual_code_o,
	output logic [const_pack::Nout*const_pack::Npi-1:0] offsets_o
);

	localparam integer Np = const_pack::Npi;

	logic [const_pack::Nsel-1:0] off_idx;

	// slot select for offset writes
	assign off_idx = cfg_data_i[const_pack::OffIdxLsb +: const_pack::Nsel];

	always_ff @(posedge clk_adc) begin
		if (rst_i) begin
			ki_shift_o <= '0;
			cdr_en_o <= 1'b1;   // loop tracks out of reset
			freeze_o <= 1'b0;
			manual_code_o <= '0;
			offsets_o <= '0;
		end else if (cfg_wr_i) begin
			case (cfg_op_i)
				const_pack::CFG_KI: begin
					ki_shift_o <= cfg_data_i[const_pack::Nki-1:0];
				end
				const_pack::CFG_MODE: begin
					cdr_en_o <= cfg_data_i[const_pack::ModeCdrEnBit];
					freeze_o <= cfg_data_i[const_pack::ModeFreezeBit];
				end
				const_pack::CFG_MANUAL: begin
					manual_code_o <= cfg_data_i[Np-1:0];
				end
				const_pack::CFG_OFFSET: begin
					// only the addressed slot changes
					offsets_o[off_idx*Np +: Np] <= cfg_data_i[Np-1:0];
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/pi_ctl_gen.sv
`timescale 1ns/1ps

`default_nettype none

module pi_ctl_gen (
	input wire logic clk_adc,
	input wire logic rst_i,

	input wire logic [const_pack::Npi-1:0] phase_i,
	input wire logic phase_valid_i,

	input wire logic cdr_en_i,
	input wire logic [const_pack::Npi-1:0] manual_code_i,
	input wire logic [const_pack::Nout*const_pack::Npi-1:0] offsets_i,   // output 0 low

	output logic [const_pack::Nout*const_pack::Npi-1:0] pi_ctl_o,
	output logic ctl_valid_o
);

	localparam integer Np = const_pack::Npi;

	logic [Np-1:0] base_code;
	logic [const_pack::Nout*Np-1:0] code_d;

	// loop phase when tracking, otherwise the fixed manual code
	assign base_code = cdr_en_i ? phase_i : manual_code_i;

	// each clock gets its own skew on top of the base
	always_comb begin
		for (int n = 0; n < const_pack::Nout; n++) begin
			code_d[n*Np +: Np] = base_code + offsets_i[n*Np +: Np];   // mod 512
		end
	end

	always_ff @(posedge clk_adc) begin
		if (rst_i) begin
			ctl_valid_o <= 1'b0;
		end else begin
			ctl_valid_o <= phase_valid_i;   // one pulse per code set
		end
	end

	// hold the last code set between valids
	always_ff @(posedge clk_adc) begin
		if (phase_valid_i) begin
			pi_ctl_o <= code_d;
		end
	end

endmodule

`default_nettype wire

//--- design/mm_cdr_loop.sv
`timescale 1ns/1ps

`default_nettype none

module mm_cdr_loop (
	input wire logic clk_adc,
	input wire logic rst_i,

	// decoded word from the decode stage
	input wire logic [const_pack::Nti*const_pack::Nsamp-1:0] samp_i,
	input wire logic [const_pack::Nti-1:0] dec_i,
	input wire logic samp_valid_i,

	// loop settings
	input wire logic [const_pack::Nki-1:0] ki_shift_i,
	input wire logic cdr_en_i,
	input wire logic freeze_i,

	output logic [const_pack::Npi-1:0] phase_o,
	output logic phase_valid_o
);

	localparam integer Ns = const_pack::Nsamp;
	localparam integer Nd = const_pack::Npd;

	// lane 3 of the last valid word, feeds lane 0 of the next
	logic [Ns-1:0] samp_prev;
	logic dec_prev;

	logic signed [Nd-1:0] pd_sum;
	logic signed [Nd-1:0] pd_scaled;
	logic [const_pack::Nacc-1:0] pd_ext;
	logic [const_pack::Nacc-1:0] acc;
	logic acc_en;

	// d*s with d = +1 for a one and -1 for a zero
	function automatic logic signed [Nd-1:0] mul_dec(
		input logic d,
		input logic [Ns-1:0] s
	);
		logic signed [Nd-1:0] ext;
		ext = $signed({{(Nd-Ns){s[Ns-1]}}, s});
		return d ? ext : -ext;
	endfunction

	// mm detector: sum of d[k-1]*s[k] - d[k]*s[k-1]
	always_comb begin
		pd_sum = mul_dec(dec_prev, samp_i[0 +: Ns]) - mul_dec(dec_i[0], samp_prev);
		for (int k = 1; k < const_pack::Nti; k++) begin
			pd_sum = pd_sum
				+ mul_dec(dec_i[k-1], samp_i[k*Ns +: Ns])
				- mul_dec(dec_i[k], samp_i[(k-1)*Ns +: Ns]);
		end
	end

	assign pd_scaled = pd_sum >>> ki_shift_i;   // integral gain
	assign pd_ext = {{(const_pack::Nacc-Nd){pd_scaled[Nd-1]}}, pd_scaled};

	assign acc_en = samp_valid_i & cdr_en_i & ~freeze_i;

	always_ff @(posedge clk_adc) begin
		if (rst_i) begin
			acc <= '0;
			samp_prev <= '0;
			dec_prev <= 1'b0;
			phase_valid_o <= 1'b0;
		end else begin
			phase_valid_o <= samp_valid_i;   // runs even with the loop off
			// history tracks every valid word so gaps don't break the detector
			if (samp_valid_i) begin
				samp_prev <= samp_i[(const_pack::Nti-1)*Ns +: Ns];
				dec_prev <= dec_i[const_pack::Nti-1];
			end
			if (acc_en) begin
				acc <= acc + pd_ext;   // wraps mod 2^Nacc
			end
		end
	end

	// phase is the integrator msbs
	assign phase_o = acc[const_pack::Nacc-1 -: const_pack::Npi];

endmodule

`default_nettype wire

//--- design/adc_code_decode.sv
`timescale 1ns/1ps

`default_nettype none

module adc_code_decode (
	input wire logic clk_adc,
	input wire logic rst_i,

	// slice words from the adc retimer
	input wire logic adc_valid_i,
	input wire logic [const_pack::Nti*const_pack::Nadc-1:0] adcout_i,
	input wire logic [const_pack::Nti-1:0] adcout_sign_i,   // 1 = positive

	// decoded samples, lane 0 in the low bits
	output logic [const_pack::Nti*const_pack::Nsamp-1:0] samp_o,  // two's complement
	output logic [const_pack::Nti-1:0] dec_o,
	output logic samp_valid_o
);

	logic [const_pack::Nti*const_pack::Nsamp-1:0] samp_d;

	// sign-magnitude to two's complement
	function automatic logic signed [const_pack::Nsamp-1:0] sm_to_signed(
		input logic [const_pack::Nadc-1:0] mag,
		input logic sgn
	);
		logic signed [const_pack::Nsamp-1:0] ext;
		ext = $signed({1'b0, mag});
		return sgn ? ext : -ext;
	endfunction

	always_comb begin
		for (int k = 0; k < const_pack::Nti; k++) begin
			samp_d[k*const_pack::Nsamp +: const_pack::Nsamp] =
				sm_to_signed(adcout_i[k*const_pack::Nadc +: const_pack::Nadc],
					adcout_sign_i[k]);
		end
	end

	always_ff @(posedge clk_adc) begin
		if (rst_i) begin
			samp_valid_o <= 1'b0;
		end else begin
			samp_valid_o <= adc_valid_i;
		end
	end

	// payload only moves on a valid word
	always_ff @(posedge clk_adc) begin
		if (adc_valid_i) begin
			samp_o <= samp_d;
			dec_o <= adcout_sign_i;   // slicer decision is just the sign
		end
	end

endmodule

`default_nettype wire

//--- design/const_pack.sv
package const_pack;

	// interleaving and datapath widths
	localparam integer Nti = 4;          // adc slices per retiming clock
	localparam integer Nadc = 8;         // slice magnitude bits
	localparam integer Npi = 9;          // pi control code
	localparam integer Nout = 4;         // interleaved pi outputs
	localparam integer Nacc = 16;        // loop filter integrator
	localparam integer Npd = 12;         // mm detector sum, covers +-4*2*255
	localparam integer Ncfg = 16;        // config write data

	// signed sample carries one extra bit for the sign
	localparam integer Nsamp = Nadc + 1;

	// config register fields
	localparam integer Nki = 3;                  // ki shift amount
	localparam integer Nsel = $clog2(Nout);      // offset slot select
	localparam integer OffIdxLsb = Npi;          // slot index sits above the offset value
	localparam integer ModeCdrEnBit = 0;
	localparam integer ModeFreezeBit = 1;

	// register selects on the config write port
	typedef enum logic [1:0] {
		CFG_KI = 2'd0,       // integral gain as a right shift
		CFG_MODE = 2'd1,     // loop enable and freeze
		CFG_MANUAL = 2'd2,   // pi code used when the loop is off
		CFG_OFFSET = 2'd3    // per-output skew
	} cfg_op_t;

endpackage
